// File: source/iob_iob2wishbone.sv
module iob_iob2wishbone #(
    parameter int READ_BYTES = 4
) (
    input  logic                            clk_i,
    input  logic                            arst_n_i,

    input  logic                            iob_avalid_i,
    input  logic [iob_wb_pkg::ADDR_W-1:0]   iob_address_i,
    input  logic [iob_wb_pkg::DATA_W-1:0]   iob_wdata_i,
    input  logic [iob_wb_pkg::STRB_W-1:0]   iob_wstrb_i,
    output logic                            iob_ready_o,
    output logic                            iob_rvalid_o,
    output logic [iob_wb_pkg::DATA_W-1:0]   iob_rdata_o,
    output logic                            iob_error_o,

    output iob_wb_pkg::wb_req_t             wb_req_o,
    input  iob_wb_pkg::wb_rsp_t             wb_rsp_i
);
    import iob_wb_pkg::*;

    localparam logic [STRB_W-1:0] RB_MASK = STRB_W'((1 << READ_BYTES) - 1);

    bridge_state_e     state_q;
    bridge_state_e     state_d;
    logic [ADDR_W-1:0] adr_q;
    logic [DATA_W-1:0] dat_q;
    logic [STRB_W-1:0] sel_q;
    logic              we_q;
    logic [DATA_W-1:0] rdata_q;
    logic              error_q;
    logic [STRB_W-1:0] rd_sel;
    logic              is_write;
    logic              in_cycle;
    logic              wb_done;
    logic              accept;

    assign is_write = |iob_wstrb_i;
    assign rd_sel   = RB_MASK << iob_address_i[1:0]; // upper lanes drop off.
    assign in_cycle = (state_q == BR_CYCLE);
    assign wb_done  = in_cycle & (wb_rsp_i.ack | wb_rsp_i.err);
    assign accept   = (state_q == BR_IDLE) & iob_avalid_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            BR_IDLE:  if (iob_avalid_i) state_d = BR_CYCLE;
            BR_CYCLE: if (wb_done) state_d = BR_DONE;
            default:  state_d = BR_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= BR_IDLE;
            error_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (wb_done) begin
                error_q <= wb_rsp_i.err;
            end
        end
    end

    // held request and returned word.
    always_ff @(posedge clk_i) begin
        if (accept) begin
            adr_q <= iob_address_i;
            dat_q <= iob_wdata_i;
            we_q  <= is_write;
            sel_q <= is_write ? iob_wstrb_i : rd_sel;
        end
        if (wb_done) begin
            rdata_q <= wb_rsp_i.dat;
        end
    end

    assign wb_req_o = '{adr: adr_q, dat: dat_q, sel: sel_q, we: we_q,
                        cyc: in_cycle, stb: in_cycle};

    assign iob_ready_o  = (state_q == BR_DONE);
    assign iob_rvalid_o = iob_ready_o & ~we_q;
    assign iob_rdata_o  = rdata_q;
    assign iob_error_o  = error_q;

endmodule

// File: source/iob_wb_pkg.sv
package iob_wb_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    // wishbone request from the bridge.
    typedef struct packed {
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] dat;
        logic [STRB_W-1:0] sel;
        logic              we;
        logic              cyc;
        logic              stb;
    } wb_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] dat;
        logic              ack;
        logic              err;
    } wb_rsp_t;

    typedef enum logic [1:0] {
        BR_IDLE,
        BR_CYCLE,
        BR_DONE
    } bridge_state_e;

    // target select from address bits 13 and 12.
    typedef enum logic [1:0] {
        REG_SRAM = 2'd0,
        REG_CSR  = 2'd1,
        REG_NONE = 2'd2
    } wb_region_e;

    localparam logic [DATA_W-1:0] CSR_ID_VALUE = 32'h1b0b_0a01;

    // register bank word offsets.
    typedef enum logic [2:0] {
        CSR_SCRATCH0 = 3'd0,
        CSR_SCRATCH1 = 3'd1,
        CSR_SCRATCH2 = 3'd2,
        CSR_SCRATCH3 = 3'd3,
        CSR_ID       = 3'd4,
        CSR_WCOUNT   = 3'd5
    } csr_addr_e;

endpackage

// File: source/iob_wb_subsys.sv
module iob_wb_subsys #(
    parameter int READ_BYTES = 4,
    parameter int SRAM_AW    = 8
) (
    input  logic                          clk_i,
    input  logic                          arst_n_i,

    input  logic                          iob_avalid_i,
    input  logic [iob_wb_pkg::ADDR_W-1:0] iob_address_i,
    input  logic [iob_wb_pkg::DATA_W-1:0] iob_wdata_i,
    input  logic [iob_wb_pkg::STRB_W-1:0] iob_wstrb_i,
    output logic                          iob_ready_o,
    output logic                          iob_rvalid_o,
    output logic [iob_wb_pkg::DATA_W-1:0] iob_rdata_o,
    output logic                          iob_error_o
);
    import iob_wb_pkg::*;

    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    wb_req_t sram_req;
    wb_rsp_t sram_rsp;
    wb_req_t csr_req;
    wb_rsp_t csr_rsp;

    iob_iob2wishbone #(.READ_BYTES(READ_BYTES)) bridge0 (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .iob_avalid_i (iob_avalid_i),
        .iob_address_i(iob_address_i),
        .iob_wdata_i  (iob_wdata_i),
        .iob_wstrb_i  (iob_wstrb_i),
        .iob_ready_o  (iob_ready_o),
        .iob_rvalid_o (iob_rvalid_o),
        .iob_rdata_o  (iob_rdata_o),
        .iob_error_o  (iob_error_o),
        .wb_req_o     (wb_req),
        .wb_rsp_i     (wb_rsp)
    );

    // address decode and response merge.
    wb_resp_combiner combiner0 (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .wb_req_i  (wb_req),
        .wb_rsp_o  (wb_rsp),
        .sram_req_o(sram_req),
        .sram_rsp_i(sram_rsp),
        .csr_req_o (csr_req),
        .csr_rsp_i (csr_rsp)
    );

    wb_sram #(.SRAM_AW(SRAM_AW)) sram0 (
        .clk_i   (clk_i),
        .arst_n_i(arst_n_i),
        .wb_req_i(sram_req),
        .wb_rsp_o(sram_rsp)
    );

    wb_csr_bank csr0 (
        .clk_i   (clk_i),
        .arst_n_i(arst_n_i),
        .wb_req_i(csr_req),
        .wb_rsp_o(csr_rsp)
    );

endmodule

// File: source/wb_csr_bank.sv
module wb_csr_bank (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  iob_wb_pkg::wb_req_t wb_req_i,
    output iob_wb_pkg::wb_rsp_t wb_rsp_o
);
    import iob_wb_pkg::*;

    logic [DATA_W-1:0] scratch_q [0:3];
    logic [DATA_W-1:0] wcount_q;
    logic [DATA_W-1:0] rdata_q;
    logic [DATA_W-1:0] rd_word;
    logic              ack_q;
    logic              err_q;
    logic              access;
    logic              bad;
    logic              wr_ok;
    csr_addr_e         offset;

    assign offset = csr_addr_e'(wb_req_i.adr[4:2]);
    assign access = wb_req_i.cyc & wb_req_i.stb & ~(ack_q | err_q);
    assign wr_ok  = access & wb_req_i.we & ~bad;

    always_comb begin
        bad     = 1'b0;
        rd_word = '0;
        case (offset)
            CSR_SCRATCH0, CSR_SCRATCH1, CSR_SCRATCH2, CSR_SCRATCH3: begin
                rd_word = scratch_q[wb_req_i.adr[3:2]];
            end
            CSR_ID: begin
                rd_word = CSR_ID_VALUE;
                bad     = wb_req_i.we; // read only.
            end
            CSR_WCOUNT: begin
                rd_word = wcount_q;
                bad     = wb_req_i.we;
            end
            default: bad = 1'b1;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            scratch_q <= '{default: '0};
            wcount_q  <= '0;
            ack_q     <= 1'b0;
            err_q     <= 1'b0;
        end else begin
            ack_q <= access & ~bad;
            err_q <= access & bad;
            if (wr_ok) begin
                for (int b = 0; b < STRB_W; b++) begin
                    if (wb_req_i.sel[b]) begin
                        scratch_q[wb_req_i.adr[3:2]][8*b +: 8] <= wb_req_i.dat[8*b +: 8];
                    end
                end
                wcount_q <= wcount_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (access) begin
            rdata_q <= bad ? '0 : rd_word;
        end
    end

    assign wb_rsp_o = '{dat: rdata_q, ack: ack_q, err: err_q};

endmodule

// File: source/wb_resp_combiner.sv
module wb_resp_combiner (
    input  logic                clk_i,
    input  logic                arst_n_i,

    input  iob_wb_pkg::wb_req_t wb_req_i,
    output iob_wb_pkg::wb_rsp_t wb_rsp_o,

    output iob_wb_pkg::wb_req_t sram_req_o,
    input  iob_wb_pkg::wb_rsp_t sram_rsp_i,

    output iob_wb_pkg::wb_req_t csr_req_o,
    input  iob_wb_pkg::wb_rsp_t csr_rsp_i
);
    import iob_wb_pkg::*;

    wb_region_e region;
    logic       none_stb;
    logic       none_err_q;

    always_comb begin
        case (wb_req_i.adr[13:12])
            2'd0:    region = REG_SRAM;
            2'd1:    region = REG_CSR;
            default: region = REG_NONE;
        endcase
    end

    // cyc goes to both targets, stb only to the selected one.
    always_comb begin
        sram_req_o     = wb_req_i;
        csr_req_o      = wb_req_i;
        sram_req_o.stb = wb_req_i.stb & (region == REG_SRAM);
        csr_req_o.stb  = wb_req_i.stb & (region == REG_CSR);
    end

    assign none_stb = wb_req_i.cyc & wb_req_i.stb & (region == REG_NONE) & ~none_err_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            none_err_q <= 1'b0;
        end else begin
            none_err_q <= none_stb; // unmapped access.
        end
    end

    always_comb begin
        case (region)
            REG_SRAM: wb_rsp_o = sram_rsp_i;
            REG_CSR:  wb_rsp_o = csr_rsp_i;
            default:  wb_rsp_o = '{dat: '0, ack: 1'b0, err: none_err_q};
        endcase
    end

endmodule

// File: source/wb_sram.sv
module wb_sram #(
    parameter int SRAM_AW = 8
) (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  iob_wb_pkg::wb_req_t wb_req_i,
    output iob_wb_pkg::wb_rsp_t wb_rsp_o
);
    import iob_wb_pkg::*;

    localparam int DEPTH = 1 << SRAM_AW;

    logic [DATA_W-1:0]  mem [0:DEPTH-1];
    logic [SRAM_AW-1:0] word_idx;
    logic [DATA_W-1:0]  rdata_q;
    logic               ack_q;
    logic               access;

    assign word_idx = wb_req_i.adr[SRAM_AW+1:2]; // word addressed.

    // stb is still high in the ack cycle.
    assign access = wb_req_i.cyc & wb_req_i.stb & ~ack_q;

    always_ff @(posedge clk_i) begin
        if (access) begin
            if (wb_req_i.we) begin
                for (int b = 0; b < STRB_W; b++) begin
                    if (wb_req_i.sel[b]) begin
                        mem[word_idx][8*b +: 8] <= wb_req_i.dat[8*b +: 8];
                    end
                end
            end
            rdata_q <= mem[word_idx]; // old word on a write.
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    assign wb_rsp_o.dat = rdata_q;
    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.err = 1'b0;

endmodule

// File: tb.f
source/iob_wb_pkg.sv
source/iob_iob2wishbone.sv
source/wb_sram.sv
source/wb_csr_bank.sv
source/wb_resp_combiner.sv
source/iob_wb_subsys.sv
verif/iob_wb_checker.sv
verif/iob_wb_tb.sv

// File: verif/iob_wb_checker.sv
module iob_wb_checker (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  logic                ready_i,
    input  logic                rvalid_i,
    input  iob_wb_pkg::wb_req_t wb_req_i,
    input  iob_wb_pkg::wb_rsp_t wb_rsp_i
);

    ready_one_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        ready_i |=> !ready_i)
        else $error("iob ready held for more than one cycle");

    // read data only on a completed read.
    rvalid_on_read: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        rvalid_i |-> (ready_i && !wb_req_i.we))
        else $error("rvalid without ready or on a write");

    stb_needs_cyc: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        wb_req_i.stb |-> wb_req_i.cyc)
        else $error("wishbone stb high without cyc");

    stb_drops_after_rsp: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (wb_req_i.stb && (wb_rsp_i.ack || wb_rsp_i.err)) |=> !wb_req_i.stb)
        else $error("wishbone stb still high after ack or err");

endmodule

bind iob_iob2wishbone iob_wb_checker chk0 (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .ready_i (iob_ready_o),
    .rvalid_i(iob_rvalid_o),
    .wb_req_i(wb_req_o),
    .wb_rsp_i(wb_rsp_i)
);

// File: verif/iob_wb_tb.sv
module iob_wb_tb;
    import iob_wb_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int N_TRANS    = 101; // requests issued over all tests.

    logic              clk_i;
    logic              arst_n_i;
    logic              iob_avalid_i;
    logic [ADDR_W-1:0] iob_address_i;
    logic [DATA_W-1:0] iob_wdata_i;
    logic [STRB_W-1:0] iob_wstrb_i;
    logic              iob_ready_o;
    logic              iob_rvalid_o;
    logic [DATA_W-1:0] iob_rdata_o;
    logic              iob_error_o;

    logic [DATA_W-1:0] sram_model [0:255];
    logic [DATA_W-1:0] csr_model [0:3];
    int unsigned       wcount_model;
    logic [31:0]       rng;
    int                data_errs;
    int                flag_errs;
    int                issued;
    int                readies;

    iob_wb_subsys dut0 (.*);

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    always @(negedge clk_i) begin
        if (iob_ready_o) readies++; // completed transfers.
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s ^= s << 13;
        s ^= s >> 17;
        s ^= s << 5;
        return s;
    endfunction

    function logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic logic [DATA_W-1:0] merge_lanes(input logic [DATA_W-1:0] old_w,
                                                       input logic [DATA_W-1:0] new_w,
                                                       input logic [STRB_W-1:0] strb);
        logic [DATA_W-1:0] res;
        res = old_w;
        for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) res[8*b +: 8] = new_w[8*b +: 8];
        end
        return res;
    endfunction

    function automatic logic [ADDR_W-1:0] csr_addr(input int unsigned off);
        return ADDR_W'(32'h1000 + 4 * off); // region 1.
    endfunction

    task automatic check_data(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                              input string msg);
        if (got !== exp) begin
            data_errs++;
            $display("Fail %0t: %s, expected %h, got %h", $time, msg, exp, got);
        end
    endtask

    task automatic check_error(input logic got, input logic exp, input string msg);
        if (got !== exp) begin
            flag_errs++;
            $display("Fail %0t: %s, error flag expected %b, got %b", $time, msg, exp, got);
        end
    endtask

    task automatic check_rvalid(input logic got, input logic exp, input string msg);
        if (got !== exp) begin
            flag_errs++;
            $display("Fail %0t: %s, rvalid expected %b, got %b", $time, msg, exp, got);
        end
    endtask

    // holds the request until ready is seen on a rising edge.
    task automatic iob_transfer(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                                input logic [STRB_W-1:0] strb, output logic [DATA_W-1:0] rdata,
                                output logic rvalid, output logic err);
        logic got_ready;
        iob_avalid_i  = 1'b1;
        iob_address_i = addr;
        iob_wdata_i   = wdata;
        iob_wstrb_i   = strb;
        issued++;
        got_ready = 1'b0;
        while (!got_ready) begin
            @(negedge clk_i);
            got_ready = iob_ready_o;
        end
        rdata  = iob_rdata_o;
        rvalid = iob_rvalid_o;
        err    = iob_error_o;
        @(posedge clk_i);
        #5;
        iob_avalid_i = 1'b0;
        iob_wstrb_i  = '0;
    endtask

    task automatic iob_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                             input logic [STRB_W-1:0] strb, input logic exp_err,
                             input string msg);
        logic [DATA_W-1:0] rdata;
        logic              rvalid;
        logic              err;
        iob_transfer(addr, wdata, strb, rdata, rvalid, err);
        check_rvalid(rvalid, 1'b0, msg);
        check_error(err, exp_err, msg);
    endtask

    task automatic iob_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] rdata,
                            output logic rvalid, output logic err);
        iob_transfer(addr, '0, '0, rdata, rvalid, err);
    endtask

    task automatic read_expect(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] exp,
                               input logic exp_err, input string msg);
        logic [DATA_W-1:0] rdata;
        logic              rvalid;
        logic              err;
        iob_read(addr, rdata, rvalid, err);
        check_rvalid(rvalid, 1'b1, msg);
        check_error(err, exp_err, msg);
        if (!exp_err) check_data(rdata, exp, msg);
    endtask

    task automatic sram_round_trip();
        logic [ADDR_W-1:0] addrs [16];
        logic [DATA_W-1:0] w;
        for (int i = 0; i < 16; i++) begin
            w        = next_rand();
            addrs[i] = ADDR_W'({w[7:0], 2'b00});
            w        = next_rand();
            sram_model[addrs[i][9:2]] = w;
            iob_write(addrs[i], w, 4'hf, 1'b0, "sram word write");
        end
        for (int i = 0; i < 16; i++) begin
            read_expect(addrs[i], sram_model[addrs[i][9:2]], 1'b0, "sram word read");
        end
    endtask

    task automatic byte_lane_writes();
        logic [STRB_W-1:0] strbs [4] = '{4'b0001, 4'b0110, 4'b1000, 4'b1010};
        logic [ADDR_W-1:0] a;
        logic [DATA_W-1:0] w;
        for (int i = 0; i < 4; i++) begin
            a = ADDR_W'(32'h200 + 4 * i);
            w = next_rand();
            sram_model[a[9:2]] = w;
            iob_write(a, w, 4'hf, 1'b0, "lane preload");
            w = next_rand();
            sram_model[a[9:2]] = merge_lanes(sram_model[a[9:2]], w, strbs[i]);
            iob_write(a, w, strbs[i], 1'b0, "partial write");
            read_expect(a, sram_model[a[9:2]], 1'b0, "partial read");
        end
    endtask

    task automatic csr_bank_access();
        logic [DATA_W-1:0] w;
        for (int i = 0; i < 4; i++) begin
            w = next_rand();
            csr_model[i] = w;
            iob_write(csr_addr(i), w, 4'hf, 1'b0, "scratch write");
            wcount_model++;
        end
        w = next_rand();
        csr_model[2] = merge_lanes(csr_model[2], w, 4'b0101);
        iob_write(csr_addr(CSR_SCRATCH2), w, 4'b0101, 1'b0, "scratch lane write");
        wcount_model++;
        for (int i = 0; i < 4; i++) begin
            read_expect(csr_addr(i), csr_model[i], 1'b0, "scratch read");
        end
        read_expect(csr_addr(CSR_ID), CSR_ID_VALUE, 1'b0, "id read");
        read_expect(csr_addr(CSR_WCOUNT), DATA_W'(wcount_model), 1'b0, "write count read");
    endtask

    // errored accesses leave the bank untouched.
    task automatic error_paths();
        iob_write(csr_addr(CSR_ID), next_rand(), 4'hf, 1'b1, "id write");
        iob_write(csr_addr(CSR_WCOUNT), next_rand(), 4'hf, 1'b1, "count write");
        iob_write(csr_addr(6), next_rand(), 4'hf, 1'b1, "offset 6 write");
        iob_write(csr_addr(7), next_rand(), 4'b0011, 1'b1, "offset 7 write");
        read_expect(csr_addr(6), '0, 1'b1, "offset 6 read");
        read_expect(32'h0000_2000, '0, 1'b1, "region 2 read");
        iob_write(32'h0000_3004, next_rand(), 4'hf, 1'b1, "region 3 write");
        read_expect(csr_addr(CSR_WCOUNT), DATA_W'(wcount_model), 1'b0, "count after errors");
        read_expect(csr_addr(CSR_ID), CSR_ID_VALUE, 1'b0, "id after errors");
        for (int i = 0; i < 4; i++) begin
            read_expect(csr_addr(i), csr_model[i], 1'b0, "scratch after errors");
        end
    endtask

    task automatic back_to_back();
        logic [ADDR_W-1:0] a;
        logic [DATA_W-1:0] w;
        for (int i = 0; i < 8; i++) begin
            a = ADDR_W'(32'h300 + 4 * i);
            w = next_rand();
            sram_model[a[9:2]] = w;
            iob_write(a, w, 4'hf, 1'b0, "b2b sram write");
            w = next_rand();
            csr_model[i % 4] = w;
            iob_write(csr_addr(i % 4), w, 4'hf, 1'b0, "b2b scratch write");
            wcount_model++;
            read_expect(a, sram_model[a[9:2]], 1'b0, "b2b sram read");
            read_expect(csr_addr(i % 4), csr_model[i % 4], 1'b0, "b2b scratch read");
        end
        read_expect(csr_addr(CSR_WCOUNT), DATA_W'(wcount_model), 1'b0, "b2b write count");
        check_data(DATA_W'(readies), DATA_W'(issued), "ready pulses against requests");
    endtask

    initial begin
        clk_i         = 1'b0;
        arst_n_i      = 1'b0;
        iob_avalid_i  = 1'b0;
        iob_address_i = '0;
        iob_wdata_i   = '0;
        iob_wstrb_i   = '0;
        rng           = 32'h9ea1;
        wcount_model  = 0;
        data_errs     = 0;
        flag_errs     = 0;
        issued        = 0;
        readies       = 0;
        repeat (3) @(posedge clk_i);
        #5;
        arst_n_i = 1'b1;
        fork
            begin
                sram_round_trip();
                byte_lane_writes();
                csr_bank_access();
                error_paths();
                back_to_back();
            end
            begin
                #(N_TRANS * 20 * CLK_PERIOD);
                $display("timeout: the DUT stopped completing requests");
                $display("TEST FAILED");
                $finish;
            end
        join_any
        $display("errors: data %0d, flags %0d, total %0d", data_errs, flag_errs,
                 data_errs + flag_errs);
        if (data_errs + flag_errs == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
